//--- tb.f
axi4s_pkg.sv
axi4s_ingress.sv
bus_pipe.sv
axi4s_egress.sv
axi4s_pipe.sv
axi4s_pipe_chk.sv
axi4s_pipe_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the AXI4-Stream pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module axi4s_pipe_tb -f tb.f -o axi4s_pipe_sim \
    && ./obj_dir/axi4s_pipe_sim \
    || exit 1

//--- axi4s_pipe_tb.sv
//##########################################################################
// AXI4-Stream pipeline testbench
// directed and random beats checked against a reference model
//##########################################################################
module axi4s_pipe_tb;
    import axi4s_pkg::*;

    localparam int LAT_BEATS       = 1;
    localparam int BURST_BEATS     = 64;
    localparam int RAND_BEATS      = 400;
    localparam int TOTAL_BEATS     = LAT_BEATS + BURST_BEATS + RAND_BEATS;
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 20 + 200;

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     s_tvalid;
    logic                     s_tready;
    logic [TDATA_WID-1:0]     s_tdata;
    logic [DATA_BYTE_WID-1:0] s_tkeep;
    logic                     s_tlast;
    logic [TID_WID-1:0]       s_tid;
    logic [TDEST_WID-1:0]     s_tdest;
    logic [TUSER_WID-1:0]     s_tuser;
    logic                     m_tvalid;
    logic                     m_tready;
    logic [TDATA_WID-1:0]     m_tdata;
    logic [DATA_BYTE_WID-1:0] m_tkeep;
    logic                     m_tlast;
    logic [TID_WID-1:0]       m_tid;
    logic [TDEST_WID-1:0]     m_tdest;
    logic [TUSER_WID-1:0]     m_tuser;
    logic [PKT_CNT_WID-1:0]   pkt_count;

    axi4s_payload_t exp_q[$];      // surviving beats, oldest first
    int             out_cyc_log[TOTAL_BEATS];
    int             cyc;           // advances on the falling edge
    int             fwd_count;
    int             out_count;
    int             exp_pkts;
    int             accept_cyc;
    logic [31:0]    stim_state;
    logic           random_stall;
    string          test_name;

    axi4s_pipe dut_i (.*);

    bind axi4s_pipe axi4s_pipe_chk chk_i (
        .clk(clk), .rst(rst),
        .s_tvalid(s_tvalid), .s_tready(s_tready), .s_tdata(s_tdata), .s_tkeep(s_tkeep),
        .s_tlast(s_tlast), .s_tid(s_tid), .s_tdest(s_tdest), .s_tuser(s_tuser),
        .m_tvalid(m_tvalid), .m_tready(m_tready), .m_tdata(m_tdata), .m_tkeep(m_tkeep),
        .m_tlast(m_tlast), .m_tid(m_tid), .m_tdest(m_tdest), .m_tuser(m_tuser),
        .pkt_count(pkt_count)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // expected master beat for one slave beat, returns 0 when it is dropped
    function automatic logic predict_beat(
        input  logic [TDATA_WID-1:0]     tdata,
        input  logic [DATA_BYTE_WID-1:0] tkeep,
        input  logic                     tlast,
        input  logic [TID_WID-1:0]       tid,
        input  logic [TDEST_WID-1:0]     tdest,
        input  logic [TUSER_WID-1:0]     tuser,
        output axi4s_payload_t           beat
    );
        beat.tuser = tuser;
        beat.tdest = tdest;
        beat.tid   = tid;
        beat.tlast = tlast;
        beat.tkeep = tkeep;
        beat.tdata = tdata;
        return (tkeep != '0) || tlast;  // no bytes and no packet end is a null beat
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_beat(input axi4s_payload_t want, input axi4s_payload_t got);
        if (got !== want) begin
            fail_run($sformatf("** Error: %s: expected %h, actual %h", test_name, want, got));
        end
    endtask

    task automatic check_count(input logic [PKT_CNT_WID-1:0] want,
                               input logic [PKT_CNT_WID-1:0] got);
        if (got !== want) begin
            fail_run($sformatf("** Error: %s: expected %0d, actual %0d", test_name, want, got));
        end
    endtask

    task automatic check_flag(input logic want, input logic got);
        if (got !== want) begin
            fail_run($sformatf("** Error: %s: expected %b, actual %b", test_name, want, got));
        end
    endtask

    task automatic check_cycles(input int want, input int got);
        if (got != want) begin
            fail_run($sformatf("** Error: %s: expected %0d cycles, actual %0d cycles",
                               test_name, want, got));
        end
    endtask

    // called on a falling edge, returns on the falling edge after the handshake
    task automatic send_random_beat(input logic force_live);
        logic [31:0]    r;
        axi4s_payload_t beat;
        logic           keep_it;
        stim_state = xorshift32(stim_state);
        s_tdata    = stim_state;
        stim_state = xorshift32(stim_state);
        r          = stim_state;
        s_tid      = r[12 +: TID_WID];
        s_tdest    = r[16 +: TDEST_WID];
        s_tuser    = r[20 +: TUSER_WID];
        if (!force_live && r[2:0] == 3'd0) begin
            s_tkeep = '0;   // forced null beat
            s_tlast = 1'b0;
        end else begin
            s_tkeep = r[3 +: DATA_BYTE_WID];
            s_tlast = (r[9:8] == 2'b00);
            if (force_live && s_tkeep == '0) begin
                s_tkeep = '1;
            end
        end
        keep_it  = predict_beat(s_tdata, s_tkeep, s_tlast, s_tid, s_tdest, s_tuser, beat);
        s_tvalid = 1'b1;
        do @(posedge clk); while (!s_tready);
        accept_cyc = cyc;
        if (keep_it) begin
            exp_q.push_back(beat);
            fwd_count++;
            if (beat.tlast) exp_pkts++;
        end
        @(negedge clk);
        s_tvalid = 1'b0;
    endtask

    initial begin : cycle_count
        cyc = 0;
        forever begin
            @(negedge clk);
            cyc++;
        end
    end

    // master back-pressure, own random stream so stimulus order stays fixed
    initial begin : ready_drive
        logic [31:0] stall_state;
        stall_state = 32'd31 + 32'h9e37_79b9;
        m_tready    = 1'b1;
        forever begin
            @(negedge clk);
            if (random_stall) begin
                stall_state = xorshift32(stall_state);
                m_tready    = (stall_state[1:0] != 2'b00);  // stall about one cycle in four
            end else begin
                m_tready = 1'b1;
            end
        end
    end

    always @(posedge clk) begin : compare_out
        axi4s_payload_t want;
        axi4s_payload_t got;
        if (!rst && m_tvalid && m_tready) begin
            if (exp_q.size() == 0) begin
                fail_run("master port delivered a beat that was never sent or was dropped");
            end else begin
                want      = exp_q.pop_front();
                got.tuser = m_tuser;
                got.tdest = m_tdest;
                got.tid   = m_tid;
                got.tlast = m_tlast;
                got.tkeep = m_tkeep;
                got.tdata = m_tdata;
                check_beat(want, got);
                if (out_count < TOTAL_BEATS) out_cyc_log[out_count] = cyc;
                out_count++;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_run($sformatf("timeout: the run did not finish within %0d cycles",
                           WATCHDOG_CYCLES));
    end

    initial begin : run_tests
        int base;
        int gap;
        rst          = 1'b1;
        s_tvalid     = 1'b0;
        s_tdata      = '0;
        s_tkeep      = '1;  // non-null idle bus, so s_tready shows the slice state
        s_tlast      = 1'b0;
        s_tid        = '0;
        s_tdest      = '0;
        s_tuser      = '0;
        stim_state   = 32'd31;
        random_stall = 1'b0;
        fwd_count    = 0;
        out_count    = 0;
        exp_pkts     = 0;
        accept_cyc   = 0;

        test_name = "reset state";
        repeat (8) begin
            @(negedge clk);
            check_flag(1'b0, m_tvalid);
            check_flag(1'b0, s_tready);
            check_count('0, pkt_count);
        end
        rst = 1'b0;
        @(negedge clk);
        check_flag(1'b0, m_tvalid);
        check_flag(1'b1, s_tready);
        check_count('0, pkt_count);

        test_name = "fixed latency";
        send_random_beat(1'b1);
        wait (out_count == fwd_count);
        @(negedge clk);
        check_cycles(PIPE_STAGES, out_cyc_log[0] - accept_cyc);

        test_name = "full throughput";
        base = out_count;
        repeat (BURST_BEATS) send_random_beat(1'b1);
        wait (out_count == fwd_count);
        @(negedge clk);
        check_cycles(BURST_BEATS - 1, out_cyc_log[base + BURST_BEATS - 1] - out_cyc_log[base]);

        test_name    = "random traffic";
        random_stall = 1'b1;
        for (int i = 0; i < RAND_BEATS; i++) begin
            stim_state = xorshift32(stim_state);
            if (stim_state[1:0] == 2'b00) begin
                gap = 1 + int'(stim_state[3:2]);
                repeat (gap) @(negedge clk);
            end
            send_random_beat(1'b0);
        end
        random_stall = 1'b0;
        wait (out_count == fwd_count);
        @(negedge clk);

        test_name = "packet count";
        check_count(PKT_CNT_WID'(exp_pkts), pkt_count);

        // every slice must have emptied, a stray or doubled beat would still be offered
        repeat (2 * PIPE_STAGES + 2) @(negedge clk);
        if (!m_tvalid) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            fail_run("master port still offers a beat after all sent beats were delivered");
        end
    end

endmodule : axi4s_pipe_tb

//--- axi4s_pipe_chk.sv
//##########################################################################
// AXI4-Stream pipeline handshake checker, bound to the top level
//##########################################################################
module axi4s_pipe_chk (
    input logic                                clk,
    input logic                                rst,
    input logic                                s_tvalid,
    input logic                                s_tready,
    input logic [axi4s_pkg::TDATA_WID-1:0]     s_tdata,
    input logic [axi4s_pkg::DATA_BYTE_WID-1:0] s_tkeep,
    input logic                                s_tlast,
    input logic [axi4s_pkg::TID_WID-1:0]       s_tid,
    input logic [axi4s_pkg::TDEST_WID-1:0]     s_tdest,
    input logic [axi4s_pkg::TUSER_WID-1:0]     s_tuser,
    input logic                                m_tvalid,
    input logic                                m_tready,
    input logic [axi4s_pkg::TDATA_WID-1:0]     m_tdata,
    input logic [axi4s_pkg::DATA_BYTE_WID-1:0] m_tkeep,
    input logic                                m_tlast,
    input logic [axi4s_pkg::TID_WID-1:0]       m_tid,
    input logic [axi4s_pkg::TDEST_WID-1:0]     m_tdest,
    input logic [axi4s_pkg::TUSER_WID-1:0]     m_tuser,
    input logic [axi4s_pkg::PKT_CNT_WID-1:0]   pkt_count
);

    // master side holds a stalled beat unchanged
    m_hold: assert property (@(posedge clk) disable iff (rst)
        m_tvalid && !m_tready |=> m_tvalid
            && $stable({m_tdata, m_tkeep, m_tlast, m_tid, m_tdest, m_tuser}))
        else $error("master beat changed or vanished while stalled");

    m_reset_idle: assert property (@(posedge clk)
        rst && $past(rst) |-> !m_tvalid)
        else $error("m_tvalid high during reset");

    // counter only moves on the last beat of a packet
    cnt_on_last: assert property (@(posedge clk) disable iff (rst)
        !(m_tvalid && m_tready && m_tlast) |=> $stable(pkt_count))
        else $error("pkt_count moved without a tlast transfer");

    s_hold: assert property (@(posedge clk) disable iff (rst)
        s_tvalid && !s_tready |=> s_tvalid
            && $stable({s_tdata, s_tkeep, s_tlast, s_tid, s_tdest, s_tuser}))
        else $error("slave beat changed or vanished while stalled");

endmodule : axi4s_pipe_chk

//--- axi4s_pipe.sv
//##########################################################################
// AXI4-Stream register pipeline top level
// ingress, slice chain and egress between one slave and one master port
//##########################################################################
module axi4s_pipe (
    input  logic                                clk,
    input  logic                                rst,
    // slave port
    input  logic                                s_tvalid,
    output logic                                s_tready,
    input  logic [axi4s_pkg::TDATA_WID-1:0]     s_tdata,
    input  logic [axi4s_pkg::DATA_BYTE_WID-1:0] s_tkeep,
    input  logic                                s_tlast,
    input  logic [axi4s_pkg::TID_WID-1:0]       s_tid,
    input  logic [axi4s_pkg::TDEST_WID-1:0]     s_tdest,
    input  logic [axi4s_pkg::TUSER_WID-1:0]     s_tuser,
    // master port
    output logic                                m_tvalid,
    input  logic                                m_tready,
    output logic [axi4s_pkg::TDATA_WID-1:0]     m_tdata,
    output logic [axi4s_pkg::DATA_BYTE_WID-1:0] m_tkeep,
    output logic                                m_tlast,
    output logic [axi4s_pkg::TID_WID-1:0]       m_tid,
    output logic [axi4s_pkg::TDEST_WID-1:0]     m_tdest,
    output logic [axi4s_pkg::TUSER_WID-1:0]     m_tuser,
    output logic [axi4s_pkg::PKT_CNT_WID-1:0]   pkt_count
);
    import axi4s_pkg::*;

    logic           in_valid;
    logic           in_ready;
    axi4s_payload_t in_payload;
    logic           out_valid;
    logic           out_ready;
    axi4s_payload_t out_payload;

    axi4s_ingress ingress_i (
        .clk, .rst,
        .s_tvalid, .s_tready, .s_tdata, .s_tkeep, .s_tlast, .s_tid, .s_tdest, .s_tuser,
        .in_valid, .in_ready, .in_payload
    );

    // both valid and ready registered once per stage
    bus_pipe #(
        .payload_t (axi4s_payload_t),
        .STAGES    (PIPE_STAGES)
    ) pipe_i (
        .clk, .rst,
        .in_valid, .in_ready, .in_payload,
        .out_valid, .out_ready, .out_payload
    );

    axi4s_egress egress_i (
        .clk, .rst,
        .out_valid, .out_ready, .out_payload,
        .m_tvalid, .m_tready, .m_tdata, .m_tkeep, .m_tlast, .m_tid, .m_tdest, .m_tuser,
        .pkt_count
    );

endmodule : axi4s_pipe

//--- axi4s_egress.sv
//##########################################################################
// AXI4-Stream egress
// unpacks the payload onto the master port and counts outgoing packets
//##########################################################################
module axi4s_egress (
    input  logic                                clk,
    input  logic                                rst,
    // from the slice chain
    input  logic                                out_valid,
    output logic                                out_ready,
    input  axi4s_pkg::axi4s_payload_t           out_payload,
    // master port
    output logic                                m_tvalid,
    input  logic                                m_tready,
    output logic [axi4s_pkg::TDATA_WID-1:0]     m_tdata,
    output logic [axi4s_pkg::DATA_BYTE_WID-1:0] m_tkeep,
    output logic                                m_tlast,
    output logic [axi4s_pkg::TID_WID-1:0]       m_tid,
    output logic [axi4s_pkg::TDEST_WID-1:0]     m_tdest,
    output logic [axi4s_pkg::TUSER_WID-1:0]     m_tuser,
    // packets that have left
    output logic [axi4s_pkg::PKT_CNT_WID-1:0]   pkt_count
);
    import axi4s_pkg::*;

    logic pkt_done;

    // handshake passes straight through
    assign m_tvalid  = out_valid;
    assign out_ready = m_tready;

    assign m_tdata = out_payload.tdata;
    assign m_tkeep = out_payload.tkeep;
    assign m_tlast = out_payload.tlast;
    assign m_tid   = out_payload.tid;
    assign m_tdest = out_payload.tdest;
    assign m_tuser = out_payload.tuser;

    // end of a packet actually transferred on the master side
    assign pkt_done = m_tvalid && m_tready && out_payload.tlast;

    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_count <= '0;
        end else if (pkt_done) begin
            pkt_count <= pkt_count + PKT_CNT_WID'(1);  // wraps at full scale
        end
    end

endmodule : axi4s_egress

//--- bus_pipe.sv
//##########################################################################
// valid/ready register slice chain
// STAGES skid slices with registered forward and reverse paths
//##########################################################################
module bus_pipe #(
    parameter type payload_t = logic [7:0],
    parameter int  STAGES    = 1  // must be 1 or more
) (
    input  logic     clk,
    input  logic     rst,
    // upstream side
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_payload,
    // downstream side
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_payload
);

    // link k feeds stage k, link STAGES is the chain output
    logic     link_valid   [STAGES+1];
    logic     link_ready   [STAGES+1];
    payload_t link_payload [STAGES+1];

    assign link_valid[0]   = in_valid;
    assign link_payload[0] = in_payload;
    assign in_ready        = link_ready[0];

    assign out_valid          = link_valid[STAGES];
    assign out_payload        = link_payload[STAGES];
    assign link_ready[STAGES] = out_ready;

    for (genvar i = 0; i < STAGES; i++) begin : g_stage
        logic     main_valid;
        logic     main_valid_nxt;
        payload_t main_data;
        logic     skid_valid;
        logic     skid_valid_nxt;
        payload_t skid_data;
        logic     ready_q;     // registered ready toward the previous link
        logic     in_fire;
        logic     load_main;
        logic     main_from_skid;
        logic     load_skid;

        assign in_fire = link_valid[i] && ready_q;

        // main entry drives the output; the skid entry catches the one beat
        // that arrives while ready is still high but the output is stalled
        always_comb begin
            main_valid_nxt = main_valid;
            skid_valid_nxt = skid_valid;
            load_main      = 1'b0;
            main_from_skid = 1'b0;
            load_skid      = 1'b0;
            if (!main_valid || link_ready[i+1]) begin
                load_main = 1'b1;
                if (skid_valid) begin
                    main_valid_nxt = 1'b1;  // drain spare first, keeps order
                    skid_valid_nxt = 1'b0;
                    main_from_skid = 1'b1;
                end else begin
                    main_valid_nxt = in_fire;
                end
            end else if (in_fire) begin
                skid_valid_nxt = 1'b1;      // output stalled, park the beat
                load_skid      = 1'b1;
            end
        end

        // control state
        always_ff @(posedge clk) begin
            if (rst) begin
                main_valid <= 1'b0;
                skid_valid <= 1'b0;
                ready_q    <= 1'b0;
            end else begin
                main_valid <= main_valid_nxt;
                skid_valid <= skid_valid_nxt;
                ready_q    <= !skid_valid_nxt;  // drops once the spare is used
            end
        end

        // payload registers
        always_ff @(posedge clk) begin
            if (load_main) begin
                main_data <= main_from_skid ? skid_data : link_payload[i];
            end
            if (load_skid) begin
                skid_data <= link_payload[i];
            end
        end

        assign link_ready[i]     = ready_q;
        assign link_valid[i+1]   = main_valid;
        assign link_payload[i+1] = main_data;
    end : g_stage

endmodule : bus_pipe

//--- axi4s_ingress.sv
//##########################################################################
// AXI4-Stream ingress
// packs slave fields into one payload word and drops null beats
//##########################################################################
module axi4s_ingress (
    input  logic                             clk,
    input  logic                             rst,
    // slave port
    input  logic                             s_tvalid,
    output logic                             s_tready,
    input  logic [axi4s_pkg::TDATA_WID-1:0]     s_tdata,
    input  logic [axi4s_pkg::DATA_BYTE_WID-1:0] s_tkeep,
    input  logic                             s_tlast,
    input  logic [axi4s_pkg::TID_WID-1:0]       s_tid,
    input  logic [axi4s_pkg::TDEST_WID-1:0]     s_tdest,
    input  logic [axi4s_pkg::TUSER_WID-1:0]     s_tuser,
    // toward the slice chain
    output logic                             in_valid,
    input  logic                             in_ready,
    output axi4s_pkg::axi4s_payload_t        in_payload
);
    import axi4s_pkg::*;

    logic null_beat;

    // a beat with no valid bytes carries nothing unless it closes a packet,
    // so only the keep-less, last-less case is treated as null
    assign null_beat = (s_tkeep == '0) && !s_tlast;

    // null beats are swallowed here, everything else goes downstream
    assign in_valid = s_tvalid && !null_beat;
    assign s_tready = null_beat ? 1'b1 : in_ready;  // accept and drop

    always_comb begin
        in_payload       = '0;
        in_payload.tuser = s_tuser;
        in_payload.tdest = s_tdest;
        in_payload.tid   = s_tid;
        in_payload.tlast = s_tlast;
        in_payload.tkeep = s_tkeep;
        in_payload.tdata = s_tdata;
    end

endmodule : axi4s_ingress

//--- axi4s_pkg.sv
//##########################################################################
// AXI4-Stream pipeline package
// stream field widths, pipeline depth and the packed beat payload
//##########################################################################
package axi4s_pkg;

    // beat geometry
    localparam int DATA_BYTE_WID = 4;
    localparam int TDATA_WID     = DATA_BYTE_WID * 8;

    // sideband widths
    localparam int TID_WID   = 2;
    localparam int TDEST_WID = 2;
    localparam int TUSER_WID = 4;

    // register slices between ingress and egress
    localparam int PIPE_STAGES = 2;

    // egress packet counter, wraps
    localparam int PKT_CNT_WID = 16;

    // one full beat as carried through the slice chain
    // field order sets the bit layout, tuser ends up on top
    typedef struct packed {
        logic [TUSER_WID-1:0]     tuser;
        logic [TDEST_WID-1:0]     tdest;
        logic [TID_WID-1:0]       tid;
        logic                     tlast;
        logic [DATA_BYTE_WID-1:0] tkeep;
        logic [TDATA_WID-1:0]     tdata;
    } axi4s_payload_t;  // 45 bits with the widths above

endpackage : axi4s_pkg
